// File: asi_defs.svh
`ifndef ASI_DEFS_SVH
`define ASI_DEFS_SVH

//////////////////////////////////////////////////
// Input buffer geometry
//////////////////////////////////////////////////

// Byte entries in the input FIFO
`define ASI_FIFO_DEPTH 16
// Pointer width, depth must stay a power of two
`define ASI_FIFO_AW 4

//////////////////////////////////////////////////
// Line timing and codes
//////////////////////////////////////////////////

// One serial bit per clock, so ten clocks per symbol
`define ASI_SYM_PERIOD 10
// Comma byte, sent with the K flag set
`define ASI_K28_5 8'hBC

// Register offsets in the AXI4-Lite window
`define ASI_REG_CTRL 4'h0
`define ASI_REG_STATUS 4'h4
`define ASI_REG_DATA_CNT 4'h8
`define ASI_REG_COMMA_CNT 4'hC

`endif

// File: asi_pkg.sv
package asi_pkg;

	// One transport-stream byte
	typedef logic [7:0] ts_byte_t;

	// Symbol before encoding
	// Bit 8 is the K flag, bits 7:0 the byte
	typedef logic [8:0] asi_sym_t;

	// Encoded word, bit 0 goes out first
	typedef logic [9:0] code10_t;

	// Running disparity of the 8b10b line
	typedef enum logic {
		RD_NEG,
		RD_POS
	} rd_t;

endpackage

// File: asi_ctrl_if.sv
`timescale 1ns/1ps
`include "asi_defs.svh"

// Control and status between register block and datapath
interface asi_ctrl_if;

	// Control fields from CTRL
	logic enable;
	logic force_comma;
	logic invert;

	// Buffer fill level, 0 up to full depth
	logic [`ASI_FIFO_AW:0] fifo_level;
	// One-cycle pulses, at most one per symbol slot
	logic data_sent;
	logic comma_sent;

	// Register side
	modport regs (
		output enable,
		output force_comma,
		output invert,
		input fifo_level,
		input data_sent,
		input comma_sent
	);

	// Transmit path side
	modport datapath (
		input enable,
		input force_comma,
		input invert,
		output fifo_level,
		output data_sent,
		output comma_sent
	);

endinterface

// File: asi_regs.sv
`timescale 1ns/1ps
`include "asi_defs.svh"

module asi_regs (
	input logic clk,
	input logic rst_n,
	input logic [3:0] axi_awaddr,
	input logic axi_awvalid,
	output logic axi_awready,
	input logic [31:0] axi_wdata,
	input logic [3:0] axi_wstrb,
	input logic axi_wvalid,
	output logic axi_wready,
	output logic [1:0] axi_bresp,
	output logic axi_bvalid,
	input logic axi_bready,
	input logic [3:0] axi_araddr,
	input logic axi_arvalid,
	output logic axi_arready,
	output logic [31:0] axi_rdata,
	output logic [1:0] axi_rresp,
	output logic axi_rvalid,
	input logic axi_rready,
	asi_ctrl_if.regs ctrl
);

	logic wr_en;
	logic rd_en;
	logic wr_start;
	logic [2:0] ctrl_reg;
	logic [31:0] data_cnt;
	logic [31:0] comma_cnt;
	logic [31:0] rd_mux;
	logic fifo_empty;

	//////////////////////////////////////////////////
	// AXI4-Lite handshakes
	//////////////////////////////////////////////////

	// Accept only with both AW and W present and no response pending
	assign wr_start = axi_awvalid && axi_wvalid && !axi_awready && !axi_bvalid;
	assign wr_en = axi_awvalid && axi_awready && axi_wvalid && axi_wready;
	assign rd_en = axi_arvalid && axi_arready;

	// Always OKAY
	assign axi_bresp = 2'b00;
	assign axi_rresp = 2'b00;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			axi_awready <= 1'b0;
			axi_wready <= 1'b0;
			axi_bvalid <= 1'b0;
		end else begin
			// Single-cycle ready pulse on both channels
			axi_awready <= wr_start;
			axi_wready <= wr_start;
			if (wr_en) begin
				axi_bvalid <= 1'b1;
			end else if (axi_bready) begin
				axi_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			axi_arready <= 1'b0;
			axi_rvalid <= 1'b0;
		end else begin
			axi_arready <= axi_arvalid && !axi_arready && !axi_rvalid;
			if (rd_en) begin
				axi_rvalid <= 1'b1;
			end else if (axi_rready) begin
				axi_rvalid <= 1'b0;
			end
		end
	end

	// Read data captured with the address
	always_ff @(posedge clk) begin
		if (rd_en) begin
			axi_rdata <= rd_mux;
		end
	end

	//////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////

	assign fifo_empty = (ctrl.fifo_level == '0);

	always_comb begin
		case (axi_araddr)
			`ASI_REG_CTRL: rd_mux = {29'd0, ctrl_reg};
			`ASI_REG_STATUS: rd_mux = {23'd0, fifo_empty, 3'd0, ctrl.fifo_level};
			`ASI_REG_DATA_CNT: rd_mux = data_cnt;
			`ASI_REG_COMMA_CNT: rd_mux = comma_cnt;
			// Holes read as zero
			default: rd_mux = 32'd0;
		endcase
	end

	// CTRL lives in byte lane 0
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl_reg <= 3'd0;
		end else if (wr_en && axi_awaddr == `ASI_REG_CTRL && axi_wstrb[0]) begin
			ctrl_reg <= axi_wdata[2:0];
		end
	end

	assign ctrl.enable = ctrl_reg[0];
	assign ctrl.force_comma = ctrl_reg[1];
	assign ctrl.invert = ctrl_reg[2];

	// Symbol counters, any write clears
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_cnt <= 32'd0;
			comma_cnt <= 32'd0;
		end else begin
			if (wr_en && axi_awaddr == `ASI_REG_DATA_CNT && |axi_wstrb) begin
				data_cnt <= 32'd0;
			end else if (ctrl.data_sent) begin
				data_cnt <= data_cnt + 32'd1;
			end
			if (wr_en && axi_awaddr == `ASI_REG_COMMA_CNT && |axi_wstrb) begin
				comma_cnt <= 32'd0;
			end else if (ctrl.comma_sent) begin
				comma_cnt <= comma_cnt + 32'd1;
			end
		end
	end

	// A response only ever follows an accepted AW and W pair
	a_bvalid_after_write: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(axi_bvalid) |-> $past(wr_en));

endmodule

// File: ts_fifo.sv
`timescale 1ns/1ps
`include "asi_defs.svh"

module ts_fifo (
	input logic clk,
	input logic rst_n,
	input asi_pkg::ts_byte_t wdata,
	input logic push,
	output logic full,
	output asi_pkg::ts_byte_t rdata,
	input logic pop,
	output logic empty,
	output logic [`ASI_FIFO_AW:0] level
);
	import asi_pkg::*;

	ts_byte_t mem [`ASI_FIFO_DEPTH];
	logic [`ASI_FIFO_AW-1:0] wr_ptr;
	logic [`ASI_FIFO_AW-1:0] rd_ptr;

	// Pointers wrap by overflow
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Level moves only when exactly one side is active
			case ({push, pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// First-word view, head byte already on rdata
	assign rdata = mem[rd_ptr];
	assign full = (level == `ASI_FIFO_DEPTH);
	assign empty = (level == '0);

	// Producer must honour full
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> !full);
	// Consumer must honour empty
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !empty);

endmodule

// File: asi_encoder_8b10b.sv
`timescale 1ns/1ps

module asi_encoder_8b10b (
	input logic clk,
	input logic rst_n,
	input asi_pkg::asi_sym_t sym,
	input logic load,
	output asi_pkg::code10_t code
);
	import asi_pkg::*;

	logic [4:0] x;
	logic [2:0] y;
	logic k;
	logic [5:0] l6;
	logic [3:0] l4;
	logic [5:0] w6;
	logic [3:0] w4;
	logic unbal6;
	logic unbal4;
	logic alt7;
	logic flip4;
	logic [9:0] word;
	rd_t rd;
	rd_t rd_mid;
	rd_t rd_next;
	code10_t code_next;

	function automatic logic [2:0] count_ones(input logic [5:0] v);
		logic [2:0] n;
		n = 3'd0;
		for (int i = 0; i < 6; i++) begin
			n = n + 3'(v[i]);
		end
		return n;
	endfunction

	function automatic rd_t toggle_rd(input rd_t r);
		return (r == RD_NEG) ? RD_POS : RD_NEG;
	endfunction

	// EDCBA and HGF fields
	assign x = sym[4:0];
	assign y = sym[7:5];
	assign k = sym[8];

	//////////////////////////////////////////////////
	// 5b/6b, RD- column, written abcdei
	//////////////////////////////////////////////////

	always_comb begin
		if (k && x == 5'd28) begin
			l6 = 6'b001111;
		end else begin
			case (x)
				5'd0: l6 = 6'b100111;
				5'd1: l6 = 6'b011101;
				5'd2: l6 = 6'b101101;
				5'd3: l6 = 6'b110001;
				5'd4: l6 = 6'b110101;
				5'd5: l6 = 6'b101001;
				5'd6: l6 = 6'b011001;
				5'd7: l6 = 6'b111000;
				5'd8: l6 = 6'b111001;
				5'd9: l6 = 6'b100101;
				5'd10: l6 = 6'b010101;
				5'd11: l6 = 6'b110100;
				5'd12: l6 = 6'b001101;
				5'd13: l6 = 6'b101100;
				5'd14: l6 = 6'b011100;
				5'd15: l6 = 6'b010111;
				5'd16: l6 = 6'b011011;
				5'd17: l6 = 6'b100011;
				5'd18: l6 = 6'b010011;
				5'd19: l6 = 6'b110010;
				5'd20: l6 = 6'b001011;
				5'd21: l6 = 6'b101010;
				5'd22: l6 = 6'b011010;
				5'd23: l6 = 6'b111010;
				5'd24: l6 = 6'b110011;
				5'd25: l6 = 6'b100110;
				5'd26: l6 = 6'b010110;
				5'd27: l6 = 6'b110110;
				5'd28: l6 = 6'b001110;
				5'd29: l6 = 6'b101110;
				5'd30: l6 = 6'b011110;
				default: l6 = 6'b101011;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Disparity choice and 3b/4b
	//////////////////////////////////////////////////

	always_comb begin
		unbal6 = (count_ones(l6) != 3'd3);
		// D.07 is balanced yet still alternates
		w6 = (rd == RD_POS && (unbal6 || x == 5'd7)) ? ~l6 : l6;
		rd_mid = unbal6 ? toggle_rd(rd) : rd;

		// Alternate x.7 avoids a run of five in the joint
		alt7 = k || (rd_mid == RD_NEG && (x == 5'd17 || x == 5'd18 || x == 5'd20))
			|| (rd_mid == RD_POS && (x == 5'd11 || x == 5'd13 || x == 5'd14));

		// RD- column, written fghj
		case (y)
			3'd0: l4 = 4'b1011;
			3'd1: l4 = 4'b1001;
			3'd2: l4 = 4'b0101;
			3'd3: l4 = 4'b1100;
			3'd4: l4 = 4'b1101;
			3'd5: l4 = 4'b1010;
			3'd6: l4 = 4'b0110;
			default: l4 = alt7 ? 4'b0111 : 4'b1110;
		endcase
		unbal4 = (count_ones({2'b00, l4}) != 3'd2);

		// Control codes use the mirrored balanced forms for y 1, 2, 5 and 6
		if (k) begin
			flip4 = (rd_mid == RD_POS)
				^ (y == 3'd1 || y == 3'd2 || y == 3'd5 || y == 3'd6);
		end else begin
			flip4 = (rd_mid == RD_POS) && (unbal4 || y == 3'd3);
		end
		w4 = flip4 ? ~l4 : l4;
		rd_next = unbal4 ? toggle_rd(rd_mid) : rd_mid;

		// a ends up in bit 0, first on the line
		word = {w6, w4};
		for (int i = 0; i < 10; i++) begin
			code_next[i] = word[9 - i];
		end
	end

	// Zero word until the first load
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd <= RD_NEG;
			code <= '0;
		end else if (load) begin
			rd <= rd_next;
			code <= code_next;
		end
	end

	// Word weight and the disparity it leaves behind agree
	a_code_weight: assert property (@(posedge clk) disable iff (!rst_n)
		load |=> ($countones(code) inside {4, 5, 6})
			&& ($countones(code) != 6 || rd == RD_POS)
			&& ($countones(code) != 4 || rd == RD_NEG));

endmodule

// File: asi_serializer.sv
`timescale 1ns/1ps
`include "asi_defs.svh"

module asi_serializer (
	input logic clk,
	input logic rst_n,
	input asi_pkg::code10_t code,
	input logic invert,
	output logic sym_tick,
	output logic out_p,
	output logic out_n
);
	import asi_pkg::*;

	localparam int CNT_W = $clog2(`ASI_SYM_PERIOD);

	logic [CNT_W-1:0] cnt;
	code10_t shreg;
	logic line_bit;

	// Symbol pacer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == CNT_W'(`ASI_SYM_PERIOD - 1)) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Slot start, first cycle out of reset included
	assign sym_tick = (cnt == '0);

	// LSB first
	assign line_bit = shreg[0] ^ invert;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shreg <= '0;
			out_p <= 1'b0;
			out_n <= 1'b1;
		end else begin
			if (sym_tick) begin
				shreg <= code;
			end else begin
				shreg <= {1'b0, shreg[9:1]};
			end
			// Registered pair, always complementary
			out_p <= line_bit;
			out_n <= ~line_bit;
		end
	end

	a_tick_period: assert property (@(posedge clk) disable iff (!rst_n)
		sym_tick |=> (!sym_tick) [*(`ASI_SYM_PERIOD - 1)] ##1 sym_tick);

endmodule

// File: asi_tx.sv
`timescale 1ns/1ps
`include "asi_defs.svh"

module asi_tx (
	input logic clk,
	input logic rst_n,
	input logic [3:0] axi_awaddr,
	input logic axi_awvalid,
	output logic axi_awready,
	input logic [31:0] axi_wdata,
	input logic [3:0] axi_wstrb,
	input logic axi_wvalid,
	output logic axi_wready,
	output logic [1:0] axi_bresp,
	output logic axi_bvalid,
	input logic axi_bready,
	input logic [3:0] axi_araddr,
	input logic axi_arvalid,
	output logic axi_arready,
	output logic [31:0] axi_rdata,
	output logic [1:0] axi_rresp,
	output logic axi_rvalid,
	input logic axi_rready,
	input asi_pkg::ts_byte_t ts_data,
	input logic ts_valid,
	output logic ts_ready,
	output logic asi_out_p,
	output logic asi_out_n
);
	import asi_pkg::*;

	asi_ctrl_if ctrl_if ();

	ts_byte_t fifo_rdata;
	logic fifo_push;
	logic fifo_pop;
	logic fifo_full;
	logic fifo_empty;
	logic [`ASI_FIFO_AW:0] fifo_level;
	logic sym_tick;
	asi_sym_t sym;
	code10_t code;

	// Register block, AXI ports match by name
	asi_regs regs_i (
		.*,
		.ctrl(ctrl_if.regs)
	);

	//////////////////////////////////////////////////
	// Input buffer
	//////////////////////////////////////////////////

	// Back-pressure holds the byte at the source
	assign ts_ready = !fifo_full;
	assign fifo_push = ts_valid && ts_ready;

	ts_fifo fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.wdata(ts_data),
		.push(fifo_push),
		.full(fifo_full),
		.rdata(fifo_rdata),
		.pop(fifo_pop),
		.empty(fifo_empty),
		.level(fifo_level)
	);

	//////////////////////////////////////////////////
	// Symbol select
	//////////////////////////////////////////////////

	// Data only when enabled, not forced and something is buffered
	assign fifo_pop = sym_tick && ctrl_if.enable && !ctrl_if.force_comma && !fifo_empty;
	// Otherwise fill the slot with a comma
	assign sym = fifo_pop ? {1'b0, fifo_rdata} : {1'b1, `ASI_K28_5};

	assign ctrl_if.data_sent = fifo_pop;
	assign ctrl_if.comma_sent = sym_tick && !fifo_pop;
	assign ctrl_if.fifo_level = fifo_level;

	// Encoded word is ready one cycle after the tick
	asi_encoder_8b10b enc_i (
		.clk(clk),
		.rst_n(rst_n),
		.sym(sym),
		.load(sym_tick),
		.code(code)
	);

	// Picks the word up at the following tick
	asi_serializer ser_i (
		.clk(clk),
		.rst_n(rst_n),
		.code(code),
		.invert(ctrl_if.invert),
		.sym_tick(sym_tick),
		.out_p(asi_out_p),
		.out_n(asi_out_n)
	);

endmodule

// File: tb_asi_model.svh
`ifndef TB_ASI_MODEL_SVH
`define TB_ASI_MODEL_SVH

//////////////////////////////////////////////////
// Reference 8b10b encoder
//////////////////////////////////////////////////

// 5b/6b codes for negative disparity, written abcdei
localparam logic [5:0] SIX_B [32] = '{
	6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
	6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
	6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
	6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b primary codes for negative disparity, written fghj
localparam logic [3:0] FOUR_B [8] = '{
	4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};

// Returns the word with a in bit 0, the first bit on the line
function automatic logic [9:0] ref_encode(input logic [7:0] d, input logic k,
		input rd_t rd_in, output rd_t rd_out);
	logic [5:0] six;
	logic [3:0] four;
	logic [9:0] seq;
	logic [9:0] word;
	rd_t rd_m;
	if (k) begin
		// K28.5 is the only control code on this line
		seq = (rd_in == RD_NEG) ? 10'b0011111010 : 10'b1100000101;
		rd_out = (rd_in == RD_NEG) ? RD_POS : RD_NEG;
	end else begin
		six = SIX_B[d[4:0]];
		// After positive disparity take the form with fewer ones
		if (rd_in == RD_POS) begin
			six = (d[4:0] == 5'd7) ? 6'b000111 : (($countones(six) > 3) ? ~six : six);
		end
		if ($countones(six) > 3) begin
			rd_m = RD_POS;
		end else if ($countones(six) < 3) begin
			rd_m = RD_NEG;
		end else begin
			rd_m = rd_in;
		end
		four = FOUR_B[d[7:5]];
		// A7 keeps runs of five out of the sub-block joint
		if (d[7:5] == 3'd7 && ((rd_m == RD_NEG && d[4:0] inside {5'd17, 5'd18, 5'd20})
				|| (rd_m == RD_POS && d[4:0] inside {5'd11, 5'd13, 5'd14}))) begin
			four = 4'b0111;
		end
		if (rd_m == RD_POS) begin
			four = (d[7:5] == 3'd3) ? 4'b0011 : (($countones(four) > 2) ? ~four : four);
		end
		if ($countones(four) > 2) begin
			rd_out = RD_POS;
		end else if ($countones(four) < 2) begin
			rd_out = RD_NEG;
		end else begin
			rd_out = rd_m;
		end
		seq = {six, four};
	end
	for (int i = 0; i < 10; i++) begin
		word[i] = seq[9 - i];
	end
	return word;
endfunction

//////////////////////////////////////////////////
// Stimulus source and compare
//////////////////////////////////////////////////

// Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1, one bit per step
function automatic logic lfsr_step();
	logic out;
	out = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (out) begin
		lfsr_state = lfsr_state ^ 8'hB8;
	end
	return out;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
		err_cnt++;
	end
endtask

`endif

// File: tb_asi_tx.sv
`timescale 1ns/1ps
`include "asi_defs.svh"

module tb_asi_tx;
	import asi_pkg::*;

	logic clk;
	logic rst_n;
	logic [3:0] axi_awaddr;
	logic axi_awvalid;
	logic axi_awready;
	logic [31:0] axi_wdata;
	logic [3:0] axi_wstrb;
	logic axi_wvalid;
	logic axi_wready;
	logic [1:0] axi_bresp;
	logic axi_bvalid;
	logic axi_bready;
	logic [3:0] axi_araddr;
	logic axi_arvalid;
	logic axi_arready;
	logic [31:0] axi_rdata;
	logic [1:0] axi_rresp;
	logic axi_rvalid;
	logic axi_rready;
	ts_byte_t ts_data;
	logic ts_valid;
	logic ts_ready;
	logic asi_out_p;
	logic asi_out_n;

	int err_cnt = 0;
	int fail_tests = 0;
	logic [7:0] lfsr_state = 8'd8;
	// Bytes accepted by the DUT and not yet seen on the line
	ts_byte_t exp_q [$];
	int rx_words = 0;
	int data_words = 0;

	// Receiver state
	logic [9:0] win;
	logic hunting;
	// Polarity last written to CTRL, as seen at the line
	logic line_inv = 1'b0;
	int nbits;
	rd_t rx_rd;
	rd_t rd_new;
	logic [9:0] comma_neg;
	logic [9:0] comma_pos;

	`include "tb_asi_model.svh"

	asi_tx dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Line receiver and checker
	//////////////////////////////////////////////////

	// Comma first, else the next queued byte
	task automatic take_word(input logic [9:0] w);
		logic [9:0] exp_w;
		rd_t nxt;
		exp_w = ref_encode(`ASI_K28_5, 1'b1, rx_rd, nxt);
		if (w != exp_w && exp_q.size() > 0) begin
			exp_w = ref_encode(exp_q.pop_front(), 1'b0, rx_rd, nxt);
			data_words++;
		end
		check("asi_word", w, exp_w);
		rx_rd = nxt;
		rx_words++;
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			hunting = 1'b1;
			win = '0;
			nbits = 0;
		end else begin
			check("asi_out_n", asi_out_n, !asi_out_p);
			// Oldest bit ends in bit 0, same order as the code word
			win = {asi_out_p ^ line_inv, win[9:1]};
			if (hunting) begin
				comma_neg = ref_encode(`ASI_K28_5, 1'b1, RD_NEG, rd_new);
				comma_pos = ref_encode(`ASI_K28_5, 1'b1, RD_POS, rd_new);
				if (win == comma_neg || win == comma_pos) begin
					hunting = 1'b0;
					nbits = 0;
					rx_rd = (win == comma_neg) ? RD_POS : RD_NEG;
				end
			end else begin
				nbits++;
				if (nbits == 10) begin
					nbits = 0;
					take_word(win);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Bus and stream tasks
	//////////////////////////////////////////////////

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		int t;
		axi_awaddr = addr;
		axi_wdata = data;
		axi_wstrb = 4'hF;
		axi_awvalid = 1'b1;
		axi_wvalid = 1'b1;
		t = 0;
		// Ready seen at a falling edge completes on the next rising edge
		do begin
			@(negedge clk);
			t++;
		end while (!(axi_awready && axi_wready) && t < 50);
		if (!(axi_awready && axi_wready)) begin
			$display("Timeout: write to offset %0h was never accepted", addr);
			err_cnt++;
		end else begin
			@(negedge clk);
			// Output register picks up the new polarity one clock later
			if (addr == `ASI_REG_CTRL) begin
				line_inv <= data[2];
			end
		end
		axi_awvalid = 1'b0;
		axi_wvalid = 1'b0;
		t = 0;
		while (!axi_bvalid && t < 50) begin
			@(negedge clk);
			t++;
		end
		if (!axi_bvalid) begin
			$display("Timeout: no write response for offset %0h", addr);
			err_cnt++;
		end else begin
			check("axi_bresp", axi_bresp, 2'b00);
		end
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
		int t;
		data = '0;
		axi_araddr = addr;
		axi_arvalid = 1'b1;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!axi_arready && t < 50);
		if (!axi_arready) begin
			$display("Timeout: read of offset %0h was never accepted", addr);
			err_cnt++;
		end else begin
			@(negedge clk);
		end
		axi_arvalid = 1'b0;
		t = 0;
		while (!axi_rvalid && t < 50) begin
			@(negedge clk);
			t++;
		end
		if (!axi_rvalid) begin
			$display("Timeout: no read data for offset %0h", addr);
			err_cnt++;
		end else begin
			check("axi_rresp", axi_rresp, 2'b00);
			data = axi_rdata;
		end
	endtask

	// Called at a falling edge, returns one edge after the transfer
	task automatic send_byte(input ts_byte_t b);
		int t;
		ts_data = b;
		ts_valid = 1'b1;
		t = 0;
		while (!ts_ready && t < 500) begin
			@(negedge clk);
			t++;
		end
		if (!ts_ready) begin
			$display("Timeout: ts_ready stayed low for byte %0h", b);
			err_cnt++;
		end else begin
			exp_q.push_back(b);
		end
		@(negedge clk);
		ts_valid = 1'b0;
	endtask

	function automatic ts_byte_t rand_byte();
		ts_byte_t b;
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr_step();
		end
		return b;
	endfunction

	task automatic wait_words(input int n);
		int target;
		int t;
		target = rx_words + n;
		t = 0;
		while (rx_words < target && t < n * `ASI_SYM_PERIOD * 2 + 100) begin
			@(negedge clk);
			t++;
		end
		if (rx_words < target) begin
			$display("Timeout: line words stopped arriving after %0d", rx_words);
			err_cnt++;
		end
	endtask

	task automatic wait_drain(input int limit);
		int t;
		t = 0;
		while (exp_q.size() != 0 && t < limit) begin
			@(negedge clk);
			t++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d accepted bytes never reached the line", exp_q.size());
			err_cnt++;
		end
	endtask

	task automatic end_test(input int num, input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
			fail_tests++;
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] rdata;
		int errs;
		int accepted;
		int t;
		int gap;
		int seen;
		ts_byte_t held;
		rst_n = 1'b0;
		axi_awaddr = '0;
		axi_awvalid = 1'b0;
		axi_wdata = '0;
		axi_wstrb = '0;
		axi_wvalid = 1'b0;
		axi_bready = 1'b1;
		axi_araddr = '0;
		axi_arvalid = 1'b0;
		axi_rready = 1'b1;
		ts_data = '0;
		ts_valid = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// Idle line, commas only
		errs = err_cnt;
		wait_words(40);
		axi_read(`ASI_REG_COMMA_CNT, rdata);
		check("comma_cnt_nonzero", rdata != 0, 1);
		axi_read(`ASI_REG_DATA_CNT, rdata);
		check("data_cnt", rdata, 0);
		end_test(1, "idle line", errs);

		// Random bytes with random gaps
		errs = err_cnt;
		axi_write(`ASI_REG_CTRL, 32'h1);
		for (int i = 0; i < 64; i++) begin
			send_byte(rand_byte());
			gap = {lfsr_step(), lfsr_step()};
			repeat (gap) @(negedge clk);
		end
		wait_drain(2000);
		check("data_words", data_words, 64);
		axi_read(`ASI_REG_DATA_CNT, rdata);
		check("data_cnt", rdata, 64);
		end_test(2, "data path", errs);

		// Forced commas hold the buffer
		errs = err_cnt;
		axi_write(`ASI_REG_CTRL, 32'h3);
		seen = data_words;
		for (int i = 0; i < 8; i++) begin
			check("ts_ready", ts_ready, 1'b1);
			send_byte(rand_byte());
		end
		wait_words(4);
		check("data_words", data_words, seen);
		check("queued_bytes", exp_q.size(), 8);
		axi_read(`ASI_REG_STATUS, rdata);
		check("status", rdata, 32'h008);
		axi_write(`ASI_REG_CTRL, 32'h1);
		wait_drain(500);
		end_test(3, "forced comma", errs);

		// Fill until ts_ready drops
		errs = err_cnt;
		axi_write(`ASI_REG_CTRL, 32'h0);
		ts_data = rand_byte();
		ts_valid = 1'b1;
		accepted = 0;
		t = 0;
		while (ts_ready && t < 2 * `ASI_FIFO_DEPTH) begin
			exp_q.push_back(ts_data);
			accepted++;
			@(negedge clk);
			ts_data = rand_byte();
			t++;
		end
		held = ts_data;
		ts_valid = 1'b0;
		check("accepted", accepted, `ASI_FIFO_DEPTH);
		check("ts_ready", ts_ready, 1'b0);
		axi_read(`ASI_REG_STATUS, rdata);
		check("status", rdata, 32'h010);
		axi_write(`ASI_REG_CTRL, 32'h1);
		send_byte(held);
		wait_drain(800);
		end_test(4, "back-pressure", errs);

		// Inverted pair, decoded through the polarity
		errs = err_cnt;
		axi_write(`ASI_REG_CTRL, 32'h5);
		for (int i = 0; i < 8; i++) begin
			send_byte(rand_byte());
		end
		wait_drain(500);
		axi_read(`ASI_REG_CTRL, rdata);
		check("ctrl", rdata, 32'h5);
		axi_write(`ASI_REG_CTRL, 32'h1);
		wait_words(4);
		end_test(5, "polarity", errs);

		// Register behavior
		errs = err_cnt;
		axi_write(`ASI_REG_CTRL, 32'h6);
		axi_read(`ASI_REG_CTRL, rdata);
		check("ctrl", rdata, 32'h6);
		axi_write(`ASI_REG_CTRL, 32'h1);
		axi_write(`ASI_REG_COMMA_CNT, 32'h0);
		axi_read(`ASI_REG_COMMA_CNT, rdata);
		// Less than one slot between clear and read
		check("comma_cnt_at_most_1", rdata <= 1, 1);
		axi_write(`ASI_REG_STATUS, 32'hFFFF_FFFF);
		axi_read(`ASI_REG_STATUS, rdata);
		check("status", rdata, 32'h100);
		axi_read(`ASI_REG_CTRL, rdata);
		check("ctrl", rdata, 32'h1);
		// Hole in the map
		axi_read(4'h2, rdata);
		check("unmapped_rdata", rdata, 0);
		end_test(6, "registers", errs);

		$display("tests 6, failed %0d, errors %0d", fail_tests, err_cnt);
		if (err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+.
asi_pkg.sv
asi_ctrl_if.sv
asi_regs.sv
ts_fifo.sv
asi_encoder_8b10b.sv
asi_serializer.sv
asi_tx.sv
tb_asi_tx.sv

// File: Bender.yml
package:
  name: asi_tx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - asi_pkg.sv
      - asi_ctrl_if.sv
      - asi_regs.sv
      - ts_fifo.sv
      - asi_encoder_8b10b.sv
      - asi_serializer.sv
      - asi_tx.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_asi_tx.sv
